// File: verilog/tlul_bridge_pkg.sv
/* TL-UL encodings for a 32-bit bridge. The integrity fields hold a per-field parity code, not SECDED
   Source IDs wider than TL_AIW are not carried */
package tlul_bridge_pkg;

    // ------------------------------
    // A and D channel opcodes
    // ------------------------------
    typedef enum logic [2:0] {
        PutFullData    = 3'h0,
        PutPartialData = 3'h1,
        Get            = 3'h4
    } tl_a_op_e;

    typedef enum logic [2:0] {
        AccessAck      = 3'h0,
        AccessAckData  = 3'h1
    } tl_d_op_e;

    // ------------------------------
    // Field widths
    // ------------------------------
    parameter int TL_SZW = 2;                // a_size, log2 of bytes
    parameter int TL_AIW = 8;                // Source ID field on the link

    // Integrity code widths, same as the SECDED fields they replace
    parameter int CMD_INTG_W  = 7;
    parameter int DATA_INTG_W = 7;

    // a_user layout, MSB first
    //   [22:18] reserved, zero
    //   [17:14] instruction type
    //   [13:7]  command integrity
    //   [6:0]   data integrity
    parameter int USER_RSVD_W = 5;
    parameter int USER_W      = USER_RSVD_W + 4 + CMD_INTG_W + DATA_INTG_W;

    // ------------------------------
    // Multi-bit boolean
    // ------------------------------
    // Only these two codes are legal. Any other value counts as a fault
    typedef logic [3:0] mubi4_t;

    parameter mubi4_t MUBI4_TRUE  = 4'h6;
    parameter mubi4_t MUBI4_FALSE = 4'h9;

endpackage

// File: verilog/tl_link_if.sv
/* One TL-UL link, A and D channel. Source IDs are TL_AIW bits wide, the mask is one bit per byte */
`timescale 1ns/1ps

interface tl_link_if import tlul_bridge_pkg::*; #(
    parameter int AW = 32,                   // Address width
    parameter int DW = 32                    // Data width
) ();

    // A channel, host to device
    logic                  a_valid;
    logic                  a_ready;
    tl_a_op_e              a_opcode;
    logic [2:0]            a_param;          // Always zero here
    logic [TL_SZW-1:0]     a_size;
    logic [DW/8-1:0]       a_mask;
    logic [TL_AIW-1:0]     a_source;
    logic [AW-1:0]         a_address;
    logic [DW-1:0]         a_data;
    logic [USER_W-1:0]     a_user;

    // D channel, device to host
    logic                  d_valid;
    logic                  d_ready;
    tl_d_op_e              d_opcode;
    logic                  d_error;
    logic [TL_AIW-1:0]     d_source;
    logic [DW-1:0]         d_data;

    modport host (
        output a_valid, a_opcode, a_param, a_size, a_mask, a_source, a_address, a_data, a_user,
        output d_ready,
        input  a_ready, d_valid, d_opcode, d_error, d_source, d_data
    );

    modport device (
        input  a_valid, a_opcode, a_param, a_size, a_mask, a_source, a_address, a_data, a_user,
        input  d_ready,
        output a_ready, d_valid, d_opcode, d_error, d_source, d_data
    );

endinterface

// File: verilog/cmd_intg_gen.sv
/* Parity integrity over command and data. Detects any odd number of flipped bits per group,
   corrects nothing */
`timescale 1ns/1ps

module cmd_intg_gen import tlul_bridge_pkg::*; #(
    parameter int AW = 32,
    parameter int DW = 32
) (
    input  mubi4_t                 instr_type_i,
    input  logic [AW-1:0]          addr_i,
    input  tl_a_op_e               opcode_i,
    input  logic [DW/8-1:0]        mask_i,
    input  logic [DW-1:0]          data_i,
    output logic [CMD_INTG_W-1:0]  cmd_intg_o,
    output logic [DATA_INTG_W-1:0] data_intg_o
);

    // Command word covered by the code, instruction type on top
    localparam int CW = 4 + AW + 3 + DW/8;

    logic [CW-1:0] cmd_vec;

    assign cmd_vec = {instr_type_i, addr_i, opcode_i, mask_i};

    // ------------------------------
    // Command code
    // ------------------------------
    // Bit k is the even parity of every command bit i with i mod 7 == k
    always_comb begin
        cmd_intg_o = '0;
        for (int i = 0; i < CW; i++) begin
            cmd_intg_o[i % CMD_INTG_W] = cmd_intg_o[i % CMD_INTG_W] ^ cmd_vec[i];
        end
    end

    // ------------------------------
    // Data code
    // ------------------------------
    // Same grouping over the data word. Computed for reads too, over whatever sits on a_data
    always_comb begin
        data_intg_o = '0;
        for (int i = 0; i < DW; i++) begin
            data_intg_o[i % DATA_INTG_W] = data_intg_o[i % DATA_INTG_W] ^ data_i[i];
        end
    end

endmodule

// File: verilog/sub2tlul.sv
/* Component request to TL-UL, one transaction in flight, responses taken in order. Needs UW >= 22
   for the read mask, IW <= TL_AIW; last is only checked for stability, no burst handling */
`timescale 1ns/1ps

module sub2tlul import tlul_bridge_pkg::*; #(
    parameter int AW = 32,
    parameter int DW = 32,
    parameter int UW = 32,
    parameter int IW = 1
) (
    input  logic            clk,
    input  logic            rst_n,

    // Component side
    input  logic            dv_i,
    input  logic [AW-1:0]   addr_i,        // Byte address
    input  logic            write_i,
    input  logic [UW-1:0]   user_i,
    input  logic [IW-1:0]   id_i,
    input  logic [DW-1:0]   wdata_i,
    input  logic [DW/8-1:0] wstrb_i,
    input  logic [2:0]      size_i,        // Upper bit ignored, TL_SZW wide on the link
    input  logic            last_i,
    output logic [DW-1:0]   rdata_o,
    output logic            hld_o,
    output logic            rd_err_o,
    output logic            wr_err_o,

    tl_link_if.host         tl_o
);

    localparam int     BC         = DW / 8;
    localparam mubi4_t INSTR_TYPE = MUBI4_FALSE;   // Data access only

    // Transaction state encodings
    localparam logic [1:0] TXN_NONE = 2'b00;
    localparam logic [1:0] TXN_GET  = 2'b01;
    localparam logic [1:0] TXN_PUT  = 2'b10;

    logic                   pending_txn;
    logic [1:0]             cur_txn;
    tl_a_op_e               opcode;
    logic [BC-1:0]          mask_local;
    logic [CMD_INTG_W-1:0]  cmd_intg;
    logic [DATA_INTG_W-1:0] data_intg;
    logic                   a_fire;
    logic                   txn_done;

    // ------------------------------
    // Request side
    // ------------------------------
    assign opcode     = !write_i ? Get : ((wstrb_i == '1) ? PutFullData : PutPartialData);
    assign mask_local = !write_i ? user_i[18 +: BC] : wstrb_i;   // Read mask from user[21:18]

    assign tl_o.a_valid   = dv_i & ~pending_txn;   // Blocked until the ack returns
    assign tl_o.a_opcode  = opcode;
    assign tl_o.a_param   = 3'h0;
    assign tl_o.a_size    = size_i[TL_SZW-1:0];
    assign tl_o.a_mask    = mask_local;
    assign tl_o.a_source  = TL_AIW'(id_i);
    assign tl_o.a_address = addr_i;
    assign tl_o.a_data    = wdata_i;
    assign tl_o.a_user    = {{USER_RSVD_W{1'b0}}, INSTR_TYPE, cmd_intg, data_intg};

    cmd_intg_gen #(
        .AW (AW),
        .DW (DW)
    ) u_intg_gen (
        .instr_type_i (INSTR_TYPE),
        .addr_i       (addr_i),
        .opcode_i     (opcode),
        .mask_i       (mask_local),
        .data_i       (wdata_i),
        .cmd_intg_o   (cmd_intg),
        .data_intg_o  (data_intg)
    );

    assign a_fire = tl_o.a_valid & tl_o.a_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending_txn <= 1'b0;
        end else if (a_fire) begin
            pending_txn <= 1'b1;
        end else if (tl_o.d_valid && tl_o.d_ready) begin
            pending_txn <= 1'b0;               // Response taken
        end
    end

    // Remembers the kind of request so hld waits for the matching ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_txn <= TXN_NONE;
        end else if (a_fire) begin
            cur_txn <= write_i ? TXN_PUT : TXN_GET;
        end else if (txn_done) begin
            cur_txn <= TXN_NONE;
        end
    end

    // ------------------------------
    // Response side
    // ------------------------------
    assign txn_done = tl_o.d_valid &
                      (((cur_txn == TXN_GET) && (tl_o.d_opcode == AccessAckData)) ||
                       ((cur_txn == TXN_PUT) && (tl_o.d_opcode == AccessAck)));

    assign tl_o.d_ready = tl_o.d_valid;        // Always accept
    assign hld_o        = dv_i & ~txn_done;    // Released in the completion cycle only
    assign rdata_o      = (txn_done && (tl_o.d_source == TL_AIW'(id_i))) ? tl_o.d_data : '0;
    assign rd_err_o     = txn_done & ~write_i & tl_o.d_error;
    assign wr_err_o     = txn_done &  write_i & tl_o.d_error;

    // New A beat only once the previous request saw its matching ack
    a_single_txn: assert property (@(posedge clk) disable iff (!rst_n)
        a_fire |-> cur_txn == TXN_NONE);

    // Device must answer with the ack type of the request in flight
    a_ack_match: assert property (@(posedge clk) disable iff (!rst_n)
        tl_o.d_valid |-> txn_done);

    // Requester keeps the request steady while held
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        dv_i && hld_o |=> dv_i && $stable({addr_i, write_i, wdata_i, wstrb_i, last_i}));

endmodule

// File: verilog/tlul_a_fifo.sv
/* A-channel request FIFO, one cycle from push to output. D channel is wired through untouched */
`timescale 1ns/1ps

module tlul_a_fifo import tlul_bridge_pkg::*; #(
    parameter int FIFO_DEPTH = 2,
    parameter int AW         = 32,
    parameter int DW         = 32
) (
    input  logic      clk,
    input  logic      rst_n,
    tl_link_if.device up_i,
    tl_link_if.host   dn_o
);

    // Entry layout, opcode in the low bits
    localparam int BC     = DW / 8;
    localparam int PA_LSB = 3;
    localparam int SZ_LSB = PA_LSB + 3;
    localparam int MK_LSB = SZ_LSB + TL_SZW;
    localparam int SR_LSB = MK_LSB + BC;
    localparam int AD_LSB = SR_LSB + TL_AIW;
    localparam int DA_LSB = AD_LSB + AW;
    localparam int US_LSB = DA_LSB + DW;
    localparam int EW     = US_LSB + USER_W;
    localparam int PW     = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNTW   = $clog2(FIFO_DEPTH + 1);

    logic [EW-1:0]   mem_q [FIFO_DEPTH];
    logic [PW-1:0]   wr_ptr_q;
    logic [PW-1:0]   rd_ptr_q;
    logic [CNTW-1:0] count_q;
    logic [EW-1:0]   head;
    logic            push;
    logic            pop;
    logic            full;

    assign full       = (count_q == CNTW'(FIFO_DEPTH));
    assign up_i.a_ready = ~full;
    assign push       = up_i.a_valid & up_i.a_ready;
    assign pop        = dn_o.a_valid & dn_o.a_ready;

    // ------------------------------
    // Storage and pointers
    // ------------------------------
    always_ff @(posedge clk) begin
        if (push) begin
            mem_q[wr_ptr_q] <= {up_i.a_user, up_i.a_data, up_i.a_address, up_i.a_source,
                                up_i.a_mask, up_i.a_size, up_i.a_param, up_i.a_opcode};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) wr_ptr_q <= (wr_ptr_q == PW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= (rd_ptr_q == PW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            if (push && !pop)      count_q <= count_q + 1'b1;
            else if (pop && !push) count_q <= count_q - 1'b1;
        end
    end

    // ------------------------------
    // Head entry downstream
    // ------------------------------
    assign head           = mem_q[rd_ptr_q];
    assign dn_o.a_valid   = (count_q != '0);            // Low out of reset
    assign dn_o.a_opcode  = tl_a_op_e'(head[2:0]);
    assign dn_o.a_param   = head[PA_LSB +: 3];
    assign dn_o.a_size    = head[SZ_LSB +: TL_SZW];
    assign dn_o.a_mask    = head[MK_LSB +: BC];
    assign dn_o.a_source  = head[SR_LSB +: TL_AIW];
    assign dn_o.a_address = head[AD_LSB +: AW];
    assign dn_o.a_data    = head[DA_LSB +: DW];
    assign dn_o.a_user    = head[US_LSB +: USER_W];

    // D channel straight through
    assign up_i.d_valid  = dn_o.d_valid;
    assign up_i.d_opcode = dn_o.d_opcode;
    assign up_i.d_error  = dn_o.d_error;
    assign up_i.d_source = dn_o.d_source;
    assign up_i.d_data   = dn_o.d_data;
    assign dn_o.d_ready  = up_i.d_ready;

    // A push into a non-empty FIFO never lands on the head entry
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push && (count_q != '0) |-> wr_ptr_q != rd_ptr_q);
    // A pop below full always has a written entry between the pointers
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop && !full |-> wr_ptr_q != rd_ptr_q);

endmodule

// File: verilog/tlul_mem_dev.sv
/* Word-addressed TL-UL SRAM, one request at a time. a_size is ignored, the mask alone selects
   bytes on a Put; out-of-range or bad-integrity requests get d_error and change nothing */
`timescale 1ns/1ps

module tlul_mem_dev import tlul_bridge_pkg::*; #(
    parameter int MEM_WORDS = 64,
    parameter int AW        = 32,
    parameter int DW        = 32
) (
    input  logic      clk,
    input  logic      rst_n,
    tl_link_if.device tl_i
);

    localparam int BC     = DW / 8;
    localparam int OFF    = $clog2(BC);            // Byte offset bits
    localparam int IDXW   = $clog2(MEM_WORDS);
    localparam int INTG_W = CMD_INTG_W + DATA_INTG_W;

    logic [DW-1:0]          mem_q [MEM_WORDS];
    logic [AW-OFF-1:0]      word_idx;
    logic [IDXW-1:0]        mem_idx;
    logic                   in_range;
    logic                   intg_err;
    logic                   req_err;
    logic                   a_fire;
    mubi4_t                 instr_type;
    logic [CMD_INTG_W-1:0]  exp_cmd;
    logic [DATA_INTG_W-1:0] exp_data;
    logic                   d_valid_q;

    assign word_idx = tl_i.a_address[AW-1:OFF];
    assign mem_idx  = word_idx[IDXW-1:0];
    assign in_range = (word_idx < (AW-OFF)'(MEM_WORDS));

    // ------------------------------
    // Integrity check
    // ------------------------------
    assign instr_type = tl_i.a_user[INTG_W +: 4];

    cmd_intg_gen #(
        .AW (AW),
        .DW (DW)
    ) u_intg_chk (
        .instr_type_i (instr_type),
        .addr_i       (tl_i.a_address),
        .opcode_i     (tl_i.a_opcode),
        .mask_i       (tl_i.a_mask),
        .data_i       (tl_i.a_data),
        .cmd_intg_o   (exp_cmd),
        .data_intg_o  (exp_data)
    );

    // Recomputed code must match, instruction type must be a legal mubi code
    assign intg_err = ({exp_cmd, exp_data} != tl_i.a_user[INTG_W-1:0]) ||
                      ((instr_type != MUBI4_TRUE) && (instr_type != MUBI4_FALSE));
    assign req_err  = ~in_range | intg_err;

    // ------------------------------
    // Array and response
    // ------------------------------
    assign tl_i.a_ready = ~d_valid_q;              // Busy until the response is taken
    assign a_fire       = tl_i.a_valid & tl_i.a_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) mem_q[i] <= '0;
        end else if (a_fire && tl_i.a_opcode != Get && !req_err) begin
            for (int b = 0; b < BC; b++) begin
                if (tl_i.a_mask[b]) mem_q[mem_idx][8*b +: 8] <= tl_i.a_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_valid_q <= 1'b0;
        end else if (a_fire) begin
            d_valid_q <= 1'b1;
        end else if (tl_i.d_ready) begin
            d_valid_q <= 1'b0;
        end
    end

    // Response payload, loaded with the request
    always_ff @(posedge clk) begin
        if (a_fire) begin
            tl_i.d_opcode <= (tl_i.a_opcode == Get) ? AccessAckData : AccessAck;
            tl_i.d_error  <= req_err;
            tl_i.d_source <= tl_i.a_source;
            tl_i.d_data   <= (tl_i.a_opcode == Get && !req_err) ? mem_q[mem_idx] : '0;
        end
    end

    assign tl_i.d_valid = d_valid_q;

    a_d_hold: assert property (@(posedge clk) disable iff (!rst_n)
        tl_i.d_valid && !tl_i.d_ready |=> tl_i.d_valid && $stable(tl_i.d_data));

endmodule

// File: verilog/tlul_sub_top.sv
/* Component port to TL-UL SRAM. One request at a time, completion marked by hld falling while dv
   is high; user[21:18] carries the read byte mask */
`timescale 1ns/1ps

module tlul_sub_top #(
    parameter int AW         = 32,
    parameter int DW         = 32,
    parameter int IW         = 1,
    parameter int UW         = 32,
    parameter int FIFO_DEPTH = 2,
    parameter int MEM_WORDS  = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            dv_i,
    input  logic [AW-1:0]   addr_i,
    input  logic            write_i,
    input  logic [UW-1:0]   user_i,
    input  logic [IW-1:0]   id_i,
    input  logic [DW-1:0]   wdata_i,
    input  logic [DW/8-1:0] wstrb_i,
    input  logic [2:0]      size_i,
    input  logic            last_i,
    output logic [DW-1:0]   rdata_o,
    output logic            hld_o,
    output logic            rd_err_o,
    output logic            wr_err_o
);

    // ------------------------------
    // Links
    // ------------------------------
    tl_link_if #(.AW(AW), .DW(DW)) tl_up ();   // Shim to FIFO
    tl_link_if #(.AW(AW), .DW(DW)) tl_dn ();   // FIFO to memory

    sub2tlul #(.AW(AW), .DW(DW), .UW(UW), .IW(IW)) u_shim (
        .clk      (clk),
        .rst_n    (rst_n),
        .dv_i     (dv_i),
        .addr_i   (addr_i),
        .write_i  (write_i),
        .user_i   (user_i),
        .id_i     (id_i),
        .wdata_i  (wdata_i),
        .wstrb_i  (wstrb_i),
        .size_i   (size_i),
        .last_i   (last_i),
        .rdata_o  (rdata_o),
        .hld_o    (hld_o),
        .rd_err_o (rd_err_o),
        .wr_err_o (wr_err_o),
        .tl_o     (tl_up)
    );

    tlul_a_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .AW(AW), .DW(DW)) u_a_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .up_i  (tl_up),
        .dn_o  (tl_dn)
    );

    tlul_mem_dev #(.MEM_WORDS(MEM_WORDS), .AW(AW), .DW(DW)) u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .tl_i  (tl_dn)
    );

endmodule

// File: testbench/tb_tests.svh
/* Request table for the test loop. Rows with the random flag set draw address, strobes and data
   from $urandom at run time, in range only */
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

localparam int NUM_TESTS = 30;

string       t_name  [NUM_TESTS];
logic        t_write [NUM_TESTS];
logic [31:0] t_addr  [NUM_TESTS];
logic [3:0]  t_wstrb [NUM_TESTS];
logic [31:0] t_wdata [NUM_TESTS];
logic        t_err   [NUM_TESTS];          // Expected rd_err or wr_err
logic        t_rand  [NUM_TESTS];

task automatic set_row(input int i, input string name, input logic wr, input logic [31:0] addr,
                       input logic [3:0] strb, input logic [31:0] data, input logic err,
                       input logic rnd);
    t_name[i]  = name;
    t_write[i] = wr;
    t_addr[i]  = addr;
    t_wstrb[i] = strb;
    t_wdata[i] = data;
    t_err[i]   = err;
    t_rand[i]  = rnd;
endtask

task automatic load_tests();
    // Columns: row, name, write, addr, wstrb, wdata, expected error, random
    set_row( 0, "wr_full_0",       1, 32'h000, 4'hf, 32'hdeadbeef, 0, 0);
    set_row( 1, "rd_full_0",       0, 32'h000, 4'h0, 32'h0,        0, 0);
    set_row( 2, "wr_full_1",       1, 32'h004, 4'hf, 32'h12345678, 0, 0);
    set_row( 3, "rd_full_1",       0, 32'h004, 4'h0, 32'h0,        0, 0);
    set_row( 4, "wr_part_b0",      1, 32'h004, 4'h1, 32'haaaaaaaa, 0, 0);
    set_row( 5, "wr_part_b2",      1, 32'h004, 4'h4, 32'h55555555, 0, 0);
    set_row( 6, "wr_part_hi",      1, 32'h004, 4'hc, 32'h99887766, 0, 0);
    set_row( 7, "rd_merged",       0, 32'h004, 4'h0, 32'h0,        0, 0);
    set_row( 8, "wr_part_odd",     1, 32'h008, 4'h5, 32'hcafef00d, 0, 0);
    set_row( 9, "rd_part_odd",     0, 32'h008, 4'h0, 32'h0,        0, 0);
    set_row(10, "rd_unwritten_a",  0, 32'h00c, 4'h0, 32'h0,        0, 0);
    set_row(11, "rd_unwritten_b",  0, 32'h0fc, 4'h0, 32'h0,        0, 0);
    set_row(12, "wr_out_of_range", 1, 32'h400, 4'hf, 32'h0badf00d, 1, 0);
    set_row(13, "rd_out_of_range", 0, 32'h400, 4'h0, 32'h0,        1, 0);
    set_row(14, "rd_alias_word0",  0, 32'h000, 4'h0, 32'h0,        0, 0);   // Low index bits of 0x400
    set_row(15, "wr_last_word",    1, 32'h0fc, 4'hf, 32'h76543210, 0, 0);
    set_row(16, "rd_last_word",    0, 32'h0fc, 4'h0, 32'h0,        0, 0);
    set_row(17, "wr_first_oor",    1, 32'h100, 4'hf, 32'h11111111, 1, 0);

    // Random sequence, mixed writes and reads
    set_row(18, "rnd_00", 1, 32'h0, 4'h0, 32'h0, 0, 1);
    set_row(19, "rnd_01", 1, 32'h0, 4'h0, 32'h0, 0, 1);
    set_row(20, "rnd_02", 0, 32'h0, 4'h0, 32'h0, 0, 1);
    set_row(21, "rnd_03", 1, 32'h0, 4'h0, 32'h0, 0, 1);
    set_row(22, "rnd_04", 0, 32'h0, 4'h0, 32'h0, 0, 1);
    set_row(23, "rnd_05", 1, 32'h0, 4'h0, 32'h0, 0, 1);
    set_row(24, "rnd_06", 1, 32'h0, 4'h0, 32'h0, 0, 1);
    set_row(25, "rnd_07", 0, 32'h0, 4'h0, 32'h0, 0, 1);
    set_row(26, "rnd_08", 0, 32'h0, 4'h0, 32'h0, 0, 1);
    set_row(27, "rnd_09", 1, 32'h0, 4'h0, 32'h0, 0, 1);
    set_row(28, "rnd_10", 0, 32'h0, 4'h0, 32'h0, 0, 1);
    set_row(29, "rnd_11", 0, 32'h0, 4'h0, 32'h0, 0, 1);
endtask

`endif

// File: testbench/tb_tlul_sub.sv
/* Runs the table rows back to back with dv held high. Random rows stay inside MEM_WORDS,
   read data is predicted by a byte-masked reference array */
`timescale 1ns/1ps

module tb_tlul_sub;

    localparam int          AW         = 32;
    localparam int          DW         = 32;
    localparam int          IW         = 1;
    localparam int          UW         = 32;
    localparam int          FIFO_DEPTH = 2;
    localparam int          MEM_WORDS  = 64;
    localparam int          CLK_HALF   = 20;          // 40 ns period
    localparam int          RST_CYCLES = 10;
    localparam logic [31:0] SEED       = 32'hf3e550a2;
    localparam logic [31:0] READ_USER  = 32'h003c_0000;   // All four read mask bits in user[21:18]

    logic          clk;
    logic          rst_n;
    logic          dv_i;
    logic [AW-1:0] addr_i;
    logic          write_i;
    logic [UW-1:0] user_i;
    logic [IW-1:0] id_i;
    logic [DW-1:0] wdata_i;
    logic [3:0]    wstrb_i;
    logic [2:0]    size_i;
    logic          last_i;
    logic [DW-1:0] rdata_o;
    logic          hld_o;
    logic          rd_err_o;
    logic          wr_err_o;

    logic [31:0]   ref_mem [MEM_WORDS];               // Expected SRAM contents
    int            errors;

    `include "tb_tests.svh"

    tlul_sub_top #(
        .AW         (AW),
        .DW         (DW),
        .IW         (IW),
        .UW         (UW),
        .FIFO_DEPTH (FIFO_DEPTH),
        .MEM_WORDS  (MEM_WORDS)
    ) i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .dv_i     (dv_i),
        .addr_i   (addr_i),
        .write_i  (write_i),
        .user_i   (user_i),
        .id_i     (id_i),
        .wdata_i  (wdata_i),
        .wstrb_i  (wstrb_i),
        .size_i   (size_i),
        .last_i   (last_i),
        .rdata_o  (rdata_o),
        .hld_o    (hld_o),
        .rd_err_o (rd_err_o),
        .wr_err_o (wr_err_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    // ------------------------------
    // Watchdog
    // ------------------------------
    initial begin
        #((RST_CYCLES + NUM_TESTS * 20) * 2 * CLK_HALF);
        $display("watchdog: run timed out before all %0d requests completed", NUM_TESTS);
        errors++;
        $display("errors: %0d", errors);
        $display("Done: errors found");
        $finish;
    end

    task automatic check_word(input string tag, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp) else begin
            $display("error %s expected %h actual %h", tag, exp, act);
            errors++;
        end
    endtask

    // One request, held until the cycle with dv high and hld low
    task automatic run_row(input int i);
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic        wr;
        logic        exp_err;
        logic        saw_hld;
        int          idx;
        addr    = t_addr[i];
        data    = t_wdata[i];
        strb    = t_wstrb[i];
        wr      = t_write[i];
        exp_err = t_err[i];
        if (t_rand[i]) begin
            addr = ($urandom % MEM_WORDS) << 2;
            data = $urandom;
            strb = 4'($urandom);
            if (strb == 4'h0) strb = 4'hf;
        end
        @(posedge clk);
        dv_i    <= 1'b1;
        write_i <= wr;
        addr_i  <= addr;
        wdata_i <= data;
        wstrb_i <= wr ? strb : 4'h0;
        user_i  <= wr ? '0 : READ_USER;
        saw_hld = 1'b0;
        @(negedge clk);
        while (hld_o) begin
            saw_hld = 1'b1;
            @(negedge clk);
        end

        // Completion cycle, outputs valid here only
        check_word({t_name[i], ".hld"}, 32'd1, {31'd0, saw_hld});
        check_word({t_name[i], ".wr_err"}, {31'd0, exp_err & wr}, {31'd0, wr_err_o});
        check_word({t_name[i], ".rd_err"}, {31'd0, exp_err & ~wr}, {31'd0, rd_err_o});
        if (!exp_err) begin
            idx = int'(addr >> 2);
            if (wr) begin
                for (int b = 0; b < 4; b++) begin
                    if (strb[b]) ref_mem[idx][8*b +: 8] = data[8*b +: 8];
                end
            end else begin
                check_word({t_name[i], ".rdata"}, ref_mem[idx], rdata_o);
            end
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        errors = 0;
        void'($urandom(SEED));
        load_tests();
        for (int w = 0; w < MEM_WORDS; w++) ref_mem[w] = '0;   // SRAM resets to zero

        rst_n   <= 1'b0;
        dv_i    <= 1'b0;
        addr_i  <= '0;
        write_i <= 1'b0;
        user_i  <= '0;
        id_i    <= '0;
        wdata_i <= '0;
        wstrb_i <= '0;
        size_i  <= 3'd2;                              // Word transfers
        last_i  <= 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Idle outputs with dv low
        @(negedge clk);
        check_word("idle.hld", 32'd0, {31'd0, hld_o});
        check_word("idle.rd_err", 32'd0, {31'd0, rd_err_o});
        check_word("idle.wr_err", 32'd0, {31'd0, wr_err_o});

        for (int i = 0; i < NUM_TESTS; i++) begin
            run_row(i);                               // dv stays high between rows
        end
        @(posedge clk);
        dv_i <= 1'b0;
        repeat (2) @(posedge clk);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+testbench
verilog/tlul_bridge_pkg.sv
verilog/tl_link_if.sv
verilog/cmd_intg_gen.sv
verilog/sub2tlul.sv
verilog/tlul_a_fifo.sv
verilog/tlul_mem_dev.sv
verilog/tlul_sub_top.sv
testbench/tb_tlul_sub.sv
